/* rtl/memCfgPkg.sv */
// **************************************************
// Memory geometry package for the dual-port block
// memory: bank shape, array shape and index types
// **************************************************
`default_nettype none

package memCfgPkg;

  // One bank is a 32-bit lane
  localparam int laneBits = 32;
  localparam int laneBytes = laneBits / 8;

  // Banks side by side form one data word
  localparam int numLanes = 2;
  localparam int dataBits = laneBits * numLanes;
  localparam int wordBytes = laneBytes * numLanes;

  // Byte address bits below the word address
  localparam int wordOffset = $clog2(wordBytes);

  // Depth of a single bank
  localparam int bankWords = 1024;
  localparam int wordIdxBits = $clog2(bankWords);

  // Banks in series extend the depth
  localparam int numBanks = 2;
  localparam int numEntries = bankWords * numBanks;

  typedef logic [$clog2(numBanks)-1:0] bankIdxT;
  typedef logic [wordIdxBits-1:0] wordIdxT;
  typedef logic [dataBits-1:0] dataT;

  // One bit per byte of a data word
  typedef logic [wordBytes-1:0] selT;

endpackage

`default_nettype wire

/* rtl/wbPkg.sv */
// **************************************************
// Wishbone bus package: address width and the
// slave port state encoding
// **************************************************
`default_nettype none

package wbPkg;

  // Byte address width on both Wishbone ports
  localparam int adrBits = 32;

  // Slave port states
  // portIdle waits for a request, portReply answers it
  typedef enum logic {
    portIdle,
    portReply
  } portStateT;

endpackage

`default_nettype wire

/* rtl/memPortIf.sv */
// **************************************************
// Decoded memory request and read data of one port,
// between the Wishbone control and the bank array
// **************************************************
`default_nettype none
`timescale 1ns/100ps

interface memPortIf;

  // Request side
  logic en;
  memCfgPkg::selT wrSel;
  memCfgPkg::bankIdxT bankIdx;
  memCfgPkg::wordIdxT wordIdx;
  memCfgPkg::dataT wrData;

  // Read word, valid the cycle after en
  memCfgPkg::dataT rdData;

  modport ctrl (
    output en, wrSel, bankIdx, wordIdx, wrData,
    input rdData
  );

  modport array (
    input en, wrSel, bankIdx, wordIdx, wrData,
    output rdData
  );

endinterface

`default_nettype wire

/* rtl/wbPortCtrl.sv */
// **************************************************
// Wishbone classic slave control for one port:
// address decode, bank request and ack/err reply
// **************************************************
`default_nettype none
`timescale 1ns/100ps

module wbPortCtrl (
  input logic A_PS,
  input logic rst,
  input logic cyc,
  input logic stb,
  input logic we,
  input memCfgPkg::selT sel,
  input logic [wbPkg::adrBits-1:0] adr,
  input memCfgPkg::dataT datWr,
  output memCfgPkg::dataT datRd,
  output logic ack,
  output logic err,
  memPortIf.ctrl mem
);

  wbPkg::portStateT state;
  logic errQ;
  logic req;
  logic inRange;

  // Word part of the byte address
  logic [wbPkg::adrBits-memCfgPkg::wordOffset-1:0] wordAddr;

  assign wordAddr = adr[wbPkg::adrBits-1:memCfgPkg::wordOffset];

  // Any word beyond the last entry is out of range
  assign inRange = (wbPkg::adrBits'(wordAddr) < memCfgPkg::numEntries);

  assign req = cyc && stb && (state == wbPkg::portIdle);

  // Bank index sits just above the word index
  assign mem.bankIdx = wordAddr[memCfgPkg::wordIdxBits +: $bits(memCfgPkg::bankIdxT)];
  assign mem.wordIdx = wordAddr[memCfgPkg::wordIdxBits-1:0];
  assign mem.wrData = datWr;
  assign mem.wrSel = we ? sel : '0;

  // Single-cycle strobe, only for accesses that hit the array
  assign mem.en = req && inRange;

  always_ff @(posedge A_PS) begin
    if (rst) begin
      state <= wbPkg::portIdle;
      errQ <= 1'b0;
    end else begin
      case (state)
        wbPkg::portIdle: begin
          if (req) begin
            state <= wbPkg::portReply;
            errQ <= !inRange;
          end
        end
        wbPkg::portReply: begin
          state <= wbPkg::portIdle;
        end
        default: begin
          state <= wbPkg::portIdle;
        end
      endcase
    end
  end

  // Reply lasts exactly the one cycle spent in portReply
  assign ack = (state == wbPkg::portReply) && !errQ;
  assign err = (state == wbPkg::portReply) && errQ;

  // Zero data outside an acknowledged read
  assign datRd = ack ? mem.rdData : '0;

endmodule

`default_nettype wire

/* rtl/bramBank.sv */
// **************************************************
// Behavioral true dual-port bank, 32 bits by 1024
// words, byte write enables and registered reads
// **************************************************
`default_nettype none
`timescale 1ns/100ps

module bramBank (
  input logic A_PS,
  input logic enA,
  input logic [memCfgPkg::laneBytes-1:0] weA,
  input memCfgPkg::wordIdxT addrA,
  input logic [memCfgPkg::laneBits-1:0] dinA,
  output logic [memCfgPkg::laneBits-1:0] doutA,
  input logic enB,
  input logic [memCfgPkg::laneBytes-1:0] weB,
  input memCfgPkg::wordIdxT addrB,
  input logic [memCfgPkg::laneBits-1:0] dinB,
  output logic [memCfgPkg::laneBits-1:0] doutB
);

  logic [memCfgPkg::laneBits-1:0] mem [memCfgPkg::bankWords];

  // Stored word with this port's selected bytes replaced
  logic [memCfgPkg::laneBits-1:0] nextA;
  logic [memCfgPkg::laneBits-1:0] nextB;

  always_comb begin
    for (int b = 0; b < memCfgPkg::laneBytes; b++) begin
      nextA[8*b +: 8] = weA[b] ? dinA[8*b +: 8] : mem[addrA][8*b +: 8];
      nextB[8*b +: 8] = weB[b] ? dinB[8*b +: 8] : mem[addrB][8*b +: 8];
    end
  end

  // Own port sees its new bytes (write-first)
  // The other port samples the old word (read-first)
  always_ff @(posedge A_PS) begin
    if (enA) begin
      doutA <= nextA;
      if (|weA) begin
        mem[addrA] <= nextA;
      end
    end
    if (enB) begin
      doutB <= nextB;
      if (|weB) begin
        mem[addrB] <= nextB;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/bankArray.sv */
// **************************************************
// Grid of banks with per-bank write steering and a
// registered bank-select read mux on each port
// **************************************************
`default_nettype none
`timescale 1ns/100ps

module bankArray (
  input logic A_PS,
  memPortIf.array portA,
  memPortIf.array portB
);

  // Read words of every bank row
  logic [memCfgPkg::numBanks-1:0][memCfgPkg::dataBits-1:0] rowRdA;
  logic [memCfgPkg::numBanks-1:0][memCfgPkg::dataBits-1:0] rowRdB;

  // Row selected by the access in flight
  memCfgPkg::bankIdxT bankSelA;
  memCfgPkg::bankIdxT bankSelB;

  for (genvar s = 0; s < memCfgPkg::numBanks; s++) begin : gRow
    logic hitA;
    logic hitB;

    assign hitA = (portA.bankIdx == memCfgPkg::bankIdxT'(s));
    assign hitB = (portB.bankIdx == memCfgPkg::bankIdxT'(s));

    for (genvar p = 0; p < memCfgPkg::numLanes; p++) begin : gLane
      bramBank bank0 (
        .A_PS  (A_PS),
        .enA   (portA.en && hitA),
        .weA   (hitA ? portA.wrSel[memCfgPkg::laneBytes*p +: memCfgPkg::laneBytes] : '0),
        .addrA (portA.wordIdx),
        .dinA  (portA.wrData[memCfgPkg::laneBits*p +: memCfgPkg::laneBits]),
        .doutA (rowRdA[s][memCfgPkg::laneBits*p +: memCfgPkg::laneBits]),
        .enB   (portB.en && hitB),
        .weB   (hitB ? portB.wrSel[memCfgPkg::laneBytes*p +: memCfgPkg::laneBytes] : '0),
        .addrB (portB.wordIdx),
        .dinB  (portB.wrData[memCfgPkg::laneBits*p +: memCfgPkg::laneBits]),
        .doutB (rowRdB[s][memCfgPkg::laneBits*p +: memCfgPkg::laneBits])
      );
    end
  end

  // Capture the row at the same edge the banks read
  always_ff @(posedge A_PS) begin
    if (portA.en) begin
      bankSelA <= portA.bankIdx;
    end
    if (portB.en) begin
      bankSelB <= portB.bankIdx;
    end
  end

  assign portA.rdData = rowRdA[bankSelA];
  assign portB.rdData = rowRdB[bankSelB];

endmodule

`default_nettype wire

/* rtl/tdpBramTop.sv */
// **************************************************
// Dual-port block memory with two Wishbone classic
// slave ports, A and B, on one clock
// **************************************************
`default_nettype none
`timescale 1ns/100ps

module tdpBramTop (
  input logic A_PS,
  input logic rst,

  // Port A
  input logic aCyc,
  input logic aStb,
  input logic aWe,
  input memCfgPkg::selT aSel,
  input logic [wbPkg::adrBits-1:0] aAdr,
  input memCfgPkg::dataT aDatWr,
  output memCfgPkg::dataT aDatRd,
  output logic aAck,
  output logic aErr,

  // Port B
  input logic bCyc,
  input logic bStb,
  input logic bWe,
  input memCfgPkg::selT bSel,
  input logic [wbPkg::adrBits-1:0] bAdr,
  input memCfgPkg::dataT bDatWr,
  output memCfgPkg::dataT bDatRd,
  output logic bAck,
  output logic bErr
);

  memPortIf portA ();
  memPortIf portB ();

  wbPortCtrl ctrlA (
    .A_PS  (A_PS),
    .rst   (rst),
    .cyc   (aCyc),
    .stb   (aStb),
    .we    (aWe),
    .sel   (aSel),
    .adr   (aAdr),
    .datWr (aDatWr),
    .datRd (aDatRd),
    .ack   (aAck),
    .err   (aErr),
    .mem   (portA)
  );

  wbPortCtrl ctrlB (
    .A_PS  (A_PS),
    .rst   (rst),
    .cyc   (bCyc),
    .stb   (bStb),
    .we    (bWe),
    .sel   (bSel),
    .adr   (bAdr),
    .datWr (bDatWr),
    .datRd (bDatRd),
    .ack   (bAck),
    .err   (bErr),
    .mem   (portB)
  );

  // Shared storage, both ports on the same clock
  bankArray array0 (
    .A_PS  (A_PS),
    .portA (portA),
    .portB (portB)
  );

endmodule

`default_nettype wire

/* dv/tbVectors.svh */
// **************************************************
// Stimulus table for the dual-port memory testbench,
// one Wishbone access per row
// **************************************************
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

  // Row fields in order are port (1 for B), we, sel, byte address, data and flags
  // Data is the write word for writes and the expected word for literal reads
  typedef struct packed {
    logic isB;
    logic we;
    memCfgPkg::selT sel;
    logic [wbPkg::adrBits-1:0] adr;
    memCfgPkg::dataT data;
    logic [2:0] flags;
  } vecT;

  // Model flag means random write data, or a read checked against the reference copy
  localparam int flagModel = 2;
  localparam int flagErr = 1;
  // Pair runs this row and the next one in the same cycle on the other port
  localparam int flagPair = 0;
  localparam int numVecs = 18;

  vecT vecs [numVecs];

  task automatic fillVectors();
    vecs[0] = '{1'b0, 1'b1, 8'hff, 32'h0000_0000, 64'h0123_4567_89ab_cdef, 3'b000};
    vecs[1] = '{1'b1, 1'b0, 8'hff, 32'h0000_0000, 64'h0123_4567_89ab_cdef, 3'b000};
    // One byte per lane
    vecs[2] = '{1'b0, 1'b1, 8'h11, 32'h0000_0000, 64'h1111_11aa_2222_22bb, 3'b000};
    vecs[3] = '{1'b1, 1'b0, 8'hff, 32'h0000_0000, 64'h0123_45aa_89ab_cdbb, 3'b000};
    // First word of bank 1
    vecs[4] = '{1'b0, 1'b1, 8'hff, 32'h0000_2000, 64'hfeed_face_cafe_beef, 3'b000};
    vecs[5] = '{1'b1, 1'b0, 8'hff, 32'h0000_0000, 64'h0123_45aa_89ab_cdbb, 3'b000};
    vecs[6] = '{1'b0, 1'b0, 8'hff, 32'h0000_2000, 64'hfeed_face_cafe_beef, 3'b000};
    // Past the last entry
    vecs[7] = '{1'b0, 1'b1, 8'hff, 32'h0000_4000, 64'hdead_dead_dead_dead, 3'b010};
    vecs[8] = '{1'b1, 1'b0, 8'hff, 32'h0000_4008, 64'h0, 3'b010};
    vecs[9] = '{1'b0, 1'b0, 8'hff, 32'h0000_0000, 64'h0123_45aa_89ab_cdbb, 3'b000};
    // Both ports write in one cycle, one per bank
    vecs[10] = '{1'b0, 1'b1, 8'hff, 32'h0000_0018, 64'h0, 3'b101};
    vecs[11] = '{1'b1, 1'b1, 8'hff, 32'h0000_2018, 64'h0, 3'b100};
    vecs[12] = '{1'b0, 1'b0, 8'hff, 32'h0000_2018, 64'h0, 3'b100};
    vecs[13] = '{1'b1, 1'b0, 8'hff, 32'h0000_0018, 64'h0, 3'b100};
    vecs[14] = '{1'b1, 1'b1, 8'h5a, 32'h0000_0018, 64'h0, 3'b100};
    // Low address bits set
    vecs[15] = '{1'b0, 1'b0, 8'hff, 32'h0000_001d, 64'h0, 3'b100};
    vecs[16] = '{1'b1, 1'b0, 8'hff, 32'h0000_2007, 64'hfeed_face_cafe_beef, 3'b000};
    vecs[17] = '{1'b0, 1'b0, 8'hff, 32'h8000_0000, 64'h0, 3'b010};
  endtask

`endif

/* dv/tdpBramTb.sv */
// **************************************************
// Testbench for the dual-port block memory, running
// a table of Wishbone accesses on ports A and B
// **************************************************
`default_nettype none
`timescale 1ns/100ps

module tdpBramTb;

  localparam int clkPeriod = 100;
  localparam int maxWait = 10;
  localparam int entryBits = $clog2(memCfgPkg::numEntries);

  logic A_PS;
  logic rst;

  // Index 0 drives port A, index 1 port B
  logic cyc [2];
  logic stb [2];
  logic we [2];
  memCfgPkg::selT sel [2];
  logic [wbPkg::adrBits-1:0] adr [2];
  memCfgPkg::dataT datWr [2];
  memCfgPkg::dataT datRd [2];
  logic ack [2];
  logic err [2];

  `include "tbVectors.svh"

  typedef logic [$clog2(numVecs)-1:0] rowIdxT;

  // Reference contents, kept with the byte-merge rule
  memCfgPkg::dataT shadow [memCfgPkg::numEntries];
  memCfgPkg::dataT expData [2];
  rowIdxT rowOf [2];
  logic [1:0] active;
  logic [1:0] pend;
  logic [1:0] portBad;
  logic [31:0] rngState;
  int passCount;
  int failCount;

  tdpBramTop dut0 (
    .A_PS(A_PS), .rst(rst),
    .aCyc(cyc[0]), .aStb(stb[0]), .aWe(we[0]), .aSel(sel[0]), .aAdr(adr[0]),
    .aDatWr(datWr[0]), .aDatRd(datRd[0]), .aAck(ack[0]), .aErr(err[0]),
    .bCyc(cyc[1]), .bStb(stb[1]), .bWe(we[1]), .bSel(sel[1]), .bAdr(adr[1]),
    .bDatWr(datWr[1]), .bDatRd(datRd[1]), .bAck(ack[1]), .bErr(err[1])
  );

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Puts one row on its port and works out the word the reply should carry
  task automatic startRow(input rowIdxT r);
    logic p;
    logic [entryBits-1:0] entry;
    memCfgPkg::dataT wrData;
    p = vecs[r].isB;
    entry = vecs[r].adr[memCfgPkg::wordOffset +: entryBits];
    wrData = vecs[r].data;
    if (vecs[r].we && vecs[r].flags[flagModel]) begin
      wrData[32 +: 32] = nextRand();
      wrData[0 +: 32] = nextRand();
    end
    if (vecs[r].flags[flagErr]) begin
      expData[p] = '0;
    end else if (vecs[r].we) begin
      // Selected bytes take the new value, the rest stay
      for (int b = 0; b < memCfgPkg::wordBytes; b++) begin
        if (vecs[r].sel[b]) begin
          shadow[entry][8*b +: 8] = wrData[8*b +: 8];
        end
      end
      expData[p] = shadow[entry];
    end else if (vecs[r].flags[flagModel]) begin
      expData[p] = shadow[entry];
    end else begin
      expData[p] = vecs[r].data;
    end
    rowOf[p] = r;
    active[p] = 1'b1;
    pend[p] = 1'b1;
    portBad[p] = 1'b0;
    cyc[p] = 1'b1;
    stb[p] = 1'b1;
    we[p] = vecs[r].we;
    sel[p] = vecs[r].sel;
    adr[p] = vecs[r].adr;
    datWr[p] = wrData;
  endtask

  task automatic pollPort(input logic p, input int waited);
    if (pend[p] && (ack[p] || err[p])) begin
      if (waited != 1) begin
        $display("Mismatch at %0t: %s latency expected 1 got %0d", $time,
          p ? "bAck" : "aAck", waited);
        portBad[p] = 1'b1;
      end
      if (err[p] !== vecs[rowOf[p]].flags[flagErr]) begin
        $display("Mismatch at %0t: %s expected %b got %b", $time, p ? "bErr" : "aErr",
          vecs[rowOf[p]].flags[flagErr], err[p]);
        portBad[p] = 1'b1;
      end
      if (ack[p] !== !vecs[rowOf[p]].flags[flagErr]) begin
        $display("Mismatch at %0t: %s expected %b got %b", $time, p ? "bAck" : "aAck",
          !vecs[rowOf[p]].flags[flagErr], ack[p]);
        portBad[p] = 1'b1;
      end
      if (datRd[p] !== expData[p]) begin
        $display("Mismatch at %0t: %s expected %h got %h", $time, p ? "bDatRd" : "aDatRd",
          expData[p], datRd[p]);
        portBad[p] = 1'b1;
      end
      pend[p] = 1'b0;
      cyc[p] = 1'b0;
      stb[p] = 1'b0;
    end
  endtask

  // Reply must be gone one cycle later
  task automatic closePort(input logic p);
    if (active[p]) begin
      if (pend[p]) begin
        $display("Row %0d: no reply arrived on port %s", rowOf[p], p ? "B" : "A");
        portBad[p] = 1'b1;
        cyc[p] = 1'b0;
        stb[p] = 1'b0;
      end else if (ack[p] || err[p]) begin
        $display("Mismatch at %0t: %s expected 0 got 1", $time, p ? "bAck|bErr" : "aAck|aErr");
        portBad[p] = 1'b1;
      end
      if (portBad[p]) begin
        failCount++;
        $display("Row %0d on port %s failed", rowOf[p], p ? "B" : "A");
      end else begin
        passCount++;
        $display("Row %0d on port %s passed", rowOf[p], p ? "B" : "A");
      end
      active[p] = 1'b0;
    end
  endtask

  task automatic runRows(input rowIdxT r, input logic pair);
    int waited;
    startRow(r);
    if (pair) begin
      startRow(r + 1'b1);
    end
    waited = 0;
    while (pend != 2'b00 && waited < maxWait) begin
      @(negedge A_PS);
      waited++;
      for (int q = 0; q < 2; q++) begin
        pollPort(q[0], waited);
      end
    end
    @(negedge A_PS);
    for (int q = 0; q < 2; q++) begin
      closePort(q[0]);
    end
  endtask

  initial begin
    A_PS = 1'b0;
    forever begin
      #(clkPeriod / 2) A_PS = ~A_PS;
    end
  end

  // Watchdog sized from the table length plus reset
  initial begin
    #((numVecs * maxWait + 10) * clkPeriod);
    $display("Watchdog expired before the table was done");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int i;
    rst = 1'b1;
    cyc = '{1'b0, 1'b0};
    stb = '{1'b0, 1'b0};
    we = '{1'b0, 1'b0};
    sel = '{8'h00, 8'h00};
    adr = '{32'h0, 32'h0};
    datWr = '{64'h0, 64'h0};
    active = 2'b00;
    pend = 2'b00;
    rngState = 32'h9f92;
    passCount = 0;
    failCount = 0;
    fillVectors();
    repeat (4) @(posedge A_PS);
    @(negedge A_PS);
    rst = 1'b0;
    i = 0;
    while (i < numVecs) begin
      runRows(rowIdxT'(i), vecs[rowIdxT'(i)].flags[flagPair]);
      i += vecs[rowIdxT'(i)].flags[flagPair] ? 2 : 1;
    end
    $display("Rows passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+dv
rtl/memCfgPkg.sv
rtl/wbPkg.sv
rtl/memPortIf.sv
rtl/wbPortCtrl.sv
rtl/bramBank.sv
rtl/bankArray.sv
rtl/tdpBramTop.sv
dv/tdpBramTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module tdpBramTb
out=$(./obj_dir/VtdpBramTb)
echo "$out"
echo "$out" | grep -qx "Test OK"
